//--- sources.f
+incdir+src
src/bpu_pkg.sv
src/inst_decoder.sv
src/bimodal_predictor.sv
src/branch_target_buffer.sv
src/next_pc_select.sv
src/bpu_top.sv
testbench/bpu_checker.sv
testbench/tb_bpu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_bpu
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_bpu.sv
`default_nettype none

module tb_bpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF = 10; // 20 ns period
    localparam int SETTLE   = 5;  // sample point after a falling edge drive

    typedef enum {ROW_PREDICT, ROW_RESOLVE, ROW_RESET} row_op_e;

    typedef struct {
        row_op_e     op;
        int          test;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        taken;
        logic [31:0] target;
        logic        exp_bon;
        logic        exp_res;
        logic [31:0] exp_pc;
    } stim_row_t;

    logic                 clk;
    logic                 rst;
    logic [31:0]          fetch_pc;
    logic [31:0]          fetch_inst;
    bpu_pkg::resolve_t    resolve;
    bpu_pkg::prediction_t pred;

    stim_row_t stim [$];
    logic [31:0] rnd_state = 32'd56945;
    logic [6:0]  plain_opcodes [8] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
                                       7'b0110111, 7'b0010111, 7'b0001111, 7'b1110011};

    int cycles = 0;
    int cycle_limit = 50;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int test_checks = 0;
    int tests_run = 0;
    int tests_ok = 0;

    bpu_top uut (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .resolve_i    (resolve),
        .pred_o       (pred)
    );

    always #(CLK_HALF) clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rv32i encoders with arbitrary register fields
    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd0, 7'b1100111};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "random plain instructions";
            2:       return "jal static and btb target";
            3:       return "branch training";
            4:       return "counter saturation";
            5:       return "btb aliasing and jalr";
            default: return "reset mid-run";
        endcase
    endfunction

    function automatic void add_predict(input int test, input logic [31:0] pc,
                                        input logic [31:0] inst, input logic bon,
                                        input logic res, input logic [31:0] exp_pc);
        stim.push_back('{ROW_PREDICT, test, pc, inst, 1'b0, 32'd0, bon, res, exp_pc});
    endfunction

    function automatic void add_resolve(input int test, input logic [31:0] pc,
                                        input logic taken, input logic [31:0] target);
        stim.push_back('{ROW_RESOLVE, test, pc, 32'd0, taken, target, 1'b0, 1'b0, 32'd0});
    endfunction

    function automatic void add_reset(input int test);
        stim.push_back('{ROW_RESET, test, 32'd0, 32'd0, 1'b0, 32'd0, 1'b0, 1'b0, 32'd0});
    endfunction

    task automatic build_stimulus();
        logic [31:0] pc;
        logic [31:0] inst;
        for (int k = 0; k < 8; k++) begin
            rnd_state = xorshift32(rnd_state);
            pc = {rnd_state[31:2], 2'b00};
            rnd_state = xorshift32(rnd_state);
            inst = {rnd_state[31:7], plain_opcodes[rnd_state[2:0]]};
            add_predict(1, pc, inst, 1'b0, 1'b0, pc + 32'd4);
        end
        // jal with offset 0x100 is later retargeted by the btb
        add_predict(2, 32'h0000_1000, enc_jal(21'h100), 1'b1, 1'b1, 32'h0000_1100);
        add_resolve(2, 32'h0000_1000, 1'b1, 32'h0000_8000);
        add_predict(2, 32'h0000_1000, enc_jal(21'h100), 1'b1, 1'b1, 32'h0000_8000);
        add_predict(3, 32'h0000_2040, enc_branch(13'h040), 1'b1, 1'b0, 32'h0000_2044);
        add_resolve(3, 32'h0000_2040, 1'b1, 32'h0000_3000);
        add_predict(3, 32'h0000_2040, enc_branch(13'h040), 1'b1, 1'b1, 32'h0000_3000);
        add_resolve(3, 32'h0000_2040, 1'b0, 32'd0);
        add_resolve(3, 32'h0000_2040, 1'b0, 32'd0);
        add_predict(3, 32'h0000_2040, enc_branch(13'h040), 1'b1, 1'b0, 32'h0000_2044);
        for (int k = 0; k < 4; k++) begin
            add_resolve(4, 32'h0000_2100, 1'b1, 32'h0000_4000);
        end
        add_resolve(4, 32'h0000_2100, 1'b0, 32'd0);
        add_predict(4, 32'h0000_2100, enc_branch(13'h1fe0), 1'b1, 1'b1, 32'h0000_4000);
        for (int k = 0; k < 3; k++) begin
            add_resolve(4, 32'h0000_2100, 1'b0, 32'd0);
        end
        add_predict(4, 32'h0000_2100, enc_branch(13'h1fe0), 1'b1, 1'b0, 32'h0000_2104);
        add_resolve(5, 32'h0000_2180, 1'b1, 32'h0000_5000);
        add_resolve(5, 32'h0000_2180, 1'b1, 32'h0000_5000);
        // same btb index under another tag
        add_predict(5, 32'h0001_2180, enc_branch(13'h010), 1'b1, 1'b1, 32'h0001_2190);
        add_predict(5, 32'h0001_2180, enc_jalr(12'h000), 1'b1, 1'b0, 32'h0001_2184);
        add_predict(5, 32'h0000_2180, enc_jalr(12'h000), 1'b1, 1'b1, 32'h0000_5000);
        // branch at 0x2040 trained taken again so the reset has state to clear
        add_resolve(6, 32'h0000_2040, 1'b1, 32'h0000_3000);
        add_resolve(6, 32'h0000_2040, 1'b1, 32'h0000_3000);
        add_predict(6, 32'h0000_2040, enc_branch(13'h040), 1'b1, 1'b1, 32'h0000_3000);
        add_reset(6);
        add_predict(6, 32'h0000_1000, enc_jal(21'h100), 1'b1, 1'b1, 32'h0000_1100);
        add_predict(6, 32'h0000_2040, enc_branch(13'h040), 1'b1, 1'b0, 32'h0000_2044);
        add_predict(6, 32'h0000_2180, enc_branch(13'h010), 1'b1, 1'b0, 32'h0000_2184);
    endtask

    task automatic compare(input string what, input logic [31:0] pc,
                           input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        test_checks = test_checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("FAILED at %0t: pc %h %s got %h expected %h", $time, pc, what, got, exp);
        end
    endtask

    task automatic apply_row(input stim_row_t row);
        case (row.op)
            ROW_PREDICT: begin
                resolve.valid = 1'b0;
                fetch_pc = row.pc;
                fetch_inst = row.inst;
                #(SETTLE);
                compare("branch_or_not", row.pc, 32'(pred.branch_or_not), 32'(row.exp_bon));
                compare("pdt_res", row.pc, 32'(pred.pdt_res), 32'(row.exp_res));
                compare("pdt_pc", row.pc, pred.pdt_pc, row.exp_pc);
                @(negedge clk);
            end
            ROW_RESOLVE: begin
                resolve.valid = 1'b1;
                resolve.taken = row.taken;
                resolve.pc = row.pc;
                resolve.target = row.target;
                @(negedge clk);
                resolve.valid = 1'b0; // one update per row
            end
            default: begin
                resolve.valid = 1'b0;
                rst = 1'b1;
                repeat (2) @(negedge clk);
                rst = 1'b0;
            end
        endcase
    endtask

    task automatic report_test(input int id);
        tests_run = tests_run + 1;
        if (test_errors == 0) begin
            tests_ok = tests_ok + 1;
        end
        $display("test %0d (%s): %s, %0d checks, %0d errors", id, test_name(id),
                 (test_errors == 0) ? "pass" : "fail", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fetch_pc = '0;
        fetch_inst = '0;
        resolve = '0;
        build_stimulus();
        cycle_limit = stim.size() * 2 + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            apply_row(stim[i]);
            if (i == stim.size() - 1 || stim[i + 1].test != stim[i].test) begin
                report_test(stim[i].test);
            end
        end
        $display("tests %0d run, %0d passed; checks %0d, errors %0d",
                 tests_run, tests_ok, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/bpu_checker.sv
`default_nettype none

module bpu_checker (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic [31:0]    fetch_pc_i,
    input wire logic [31:0]    fetch_inst_i,
    input bpu_pkg::resolve_t    resolve_i,
    input bpu_pkg::prediction_t pred_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic resolve_seen_q; // any training since the last reset
    logic is_branch;

    assign is_branch = (fetch_inst_i[6:0] == bpu_pkg::OP_BRANCH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resolve_seen_q <= 1'b0;
        end else if (resolve_i.valid) begin
            resolve_seen_q <= 1'b1;
        end
    end

    // a taken prediction only for control transfers
    taken_needs_branch: assert property (@(posedge clk) disable iff (rst)
        pred_i.pdt_res |-> pred_i.branch_or_not)
        else $error("taken prediction for a plain instruction");

    // sequential fetch continues at pc + 4
    plain_is_sequential: assert property (@(posedge clk) disable iff (rst)
        !pred_i.branch_or_not |-> (pred_i.pdt_pc == fetch_pc_i + 32'd4))
        else $error("plain instruction redirected away from pc + 4");

    // counters start weakly not-taken, nothing trained yet
    cold_branch_not_taken: assert property (@(posedge clk) disable iff (rst)
        (!resolve_seen_q && is_branch) |-> !pred_i.pdt_res)
        else $error("branch predicted taken before any resolve");

endmodule

bind bpu_top bpu_checker u_chk (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc_i),
    .fetch_inst_i (fetch_inst_i),
    .resolve_i    (resolve_i),
    .pred_i       (pred_o)
);

`default_nettype wire

//--- src/bpu_top.sv
`default_nettype none

`include "bpu_defs.svh"

module bpu_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] fetch_pc_i,
    input  wire logic [`BPU_XLEN-1:0] fetch_inst_i,
    input  bpu_pkg::resolve_t         resolve_i,
    output bpu_pkg::prediction_t      pred_o
);

    bpu_pkg::decode_t     dec;
    logic                 bim_taken;
    logic                 btb_hit;
    logic [`BPU_XLEN-1:0] btb_target;

    // fetch side decode
    inst_decoder u_dec (
        .fetch_pc_i   (fetch_pc_i),
        .fetch_inst_i (fetch_inst_i),
        .dec_o        (dec)
    );

    // direction
    bimodal_predictor u_bim (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (fetch_pc_i),
        .resolve_i   (resolve_i),
        .taken_o     (bim_taken)
    );

    // target
    branch_target_buffer u_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (fetch_pc_i),
        .resolve_i   (resolve_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    next_pc_select u_sel (
        .dec_i        (dec),
        .dir_taken_i  (bim_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

//--- src/next_pc_select.sv
`default_nettype none

`include "bpu_defs.svh"

module next_pc_select (
    input  bpu_pkg::decode_t          dec_i,
    input  wire logic                 dir_taken_i,
    input  wire logic                 btb_hit_i,
    input  wire logic [`BPU_XLEN-1:0] btb_target_i,
    output bpu_pkg::prediction_t      pred_o
);

    logic [`BPU_XLEN-1:0] redirect_pc;

    // btb wins over the decoded target when present
    assign redirect_pc = btb_hit_i ? btb_target_i : dec_i.target_pc;

    always_comb begin
        pred_o.branch_or_not = 1'b1;
        pred_o.pdt_res       = 1'b0;
        pred_o.pdt_pc        = dec_i.fall_pc;

        case (dec_i.kind)
            bpu_pkg::KIND_NONE: begin
                pred_o.branch_or_not = 1'b0; // plain sequential fetch
            end
            bpu_pkg::KIND_JAL: begin
                pred_o.pdt_res = 1'b1; // unconditional
                pred_o.pdt_pc  = redirect_pc;
            end
            bpu_pkg::KIND_BRANCH: begin
                pred_o.pdt_res = dir_taken_i;
                if (dir_taken_i) begin
                    pred_o.pdt_pc = redirect_pc;
                end
            end
            bpu_pkg::KIND_JALR: begin
                // no static target, so a btb hit is needed to redirect
                if (dir_taken_i && btb_hit_i) begin
                    pred_o.pdt_res = 1'b1;
                    pred_o.pdt_pc  = btb_target_i;
                end
            end
            default: begin
                pred_o.branch_or_not = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/branch_target_buffer.sv
`default_nettype none

`include "bpu_defs.svh"

module branch_target_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] lookup_pc_i,
    input  bpu_pkg::resolve_t         resolve_i,
    output logic                      hit_o,
    output logic [`BPU_XLEN-1:0]      target_o
);

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);

    // direct mapped storage
    logic                      valid_q  [`BPU_BTB_ENTRIES];
    logic [`BPU_BTB_TAG_W-1:0] tag_q    [`BPU_BTB_ENTRIES];
    logic [`BPU_XLEN-1:0]      target_q [`BPU_BTB_ENTRIES];

    logic [IDX_W-1:0]          lkp_idx;
    logic [`BPU_BTB_TAG_W-1:0] lkp_tag;
    logic [IDX_W-1:0]          upd_idx;
    logic [`BPU_BTB_TAG_W-1:0] upd_tag;
    logic                      fill;

    assign lkp_idx = lookup_pc_i[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign lkp_tag = lookup_pc_i[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
    assign upd_idx = resolve_i.pc[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign upd_tag = resolve_i.pc[`BPU_XLEN-1:`BPU_BTB_TAG_LO];

    // only taken transfers allocate
    assign fill = resolve_i.valid && resolve_i.taken;

    // lookup, same cycle as fetch
    assign hit_o    = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);
    assign target_o = target_q[lkp_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // tag and target simply overwritten on fill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= resolve_i.target; // replaces any older entry
        end
    end

endmodule

`default_nettype wire

//--- src/bimodal_predictor.sv
`default_nettype none

`include "bpu_defs.svh"

module bimodal_predictor (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`BPU_XLEN-1:0] lookup_pc_i,
    input  bpu_pkg::resolve_t         resolve_i,
    output logic                      taken_o
);

    localparam int IDX_W = $clog2(`BPU_BIM_ENTRIES);

    // 2-bit saturating counters
    logic [1:0]       ctr_q [`BPU_BIM_ENTRIES];

    logic [IDX_W-1:0] lkp_idx;
    logic [IDX_W-1:0] upd_idx;
    logic [1:0]       upd_cur;
    logic [1:0]       upd_nxt;

    assign lkp_idx = lookup_pc_i[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];
    assign upd_idx = resolve_i.pc[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];

    // msb of counter is the direction
    assign taken_o = ctr_q[lkp_idx][1];

    assign upd_cur = ctr_q[upd_idx];

    // saturating step toward the resolved outcome
    always_comb begin
        upd_nxt = upd_cur;
        if (resolve_i.taken) begin
            if (upd_cur != `BPU_CTR_MAX) begin
                upd_nxt = upd_cur + 2'd1;
            end
        end else begin
            if (upd_cur != `BPU_CTR_MIN) begin
                upd_nxt = upd_cur - 2'd1;
            end
        end
    end

    // every valid resolve trains, taken or not
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
                ctr_q[i] <= `BPU_CTR_INIT;
            end
        end else if (resolve_i.valid) begin
            ctr_q[upd_idx] <= upd_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none

`include "bpu_defs.svh"

module inst_decoder (
    input  wire logic [`BPU_XLEN-1:0] fetch_pc_i,
    input  wire logic [`BPU_XLEN-1:0] fetch_inst_i,
    output bpu_pkg::decode_t          dec_o
);

    logic [`BPU_OPC_HI:`BPU_OPC_LO] opcode;
    bpu_pkg::inst_kind_e            kind;
    logic [`BPU_XLEN-1:0]           b_imm;
    logic [`BPU_XLEN-1:0]           j_imm;
    logic [`BPU_XLEN-1:0]           fall_pc;
    logic [`BPU_XLEN-1:0]           target_pc;

    assign opcode = fetch_inst_i[`BPU_OPC_HI:`BPU_OPC_LO];

    // classify by major opcode only
    always_comb begin
        case (opcode)
            bpu_pkg::OP_BRANCH: kind = bpu_pkg::KIND_BRANCH;
            bpu_pkg::OP_JAL:    kind = bpu_pkg::KIND_JAL;
            bpu_pkg::OP_JALR:   kind = bpu_pkg::KIND_JALR;
            default:            kind = bpu_pkg::KIND_NONE;
        endcase
    end

    // B-type offset, bit 0 always zero
    assign b_imm = {{20{fetch_inst_i[31]}}, fetch_inst_i[7], fetch_inst_i[30:25],
                    fetch_inst_i[11:8], 1'b0};

    // J-type offset
    assign j_imm = {{12{fetch_inst_i[31]}}, fetch_inst_i[19:12], fetch_inst_i[20],
                    fetch_inst_i[30:21], 1'b0};

    assign fall_pc = fetch_pc_i + `BPU_XLEN'(4);

    always_comb begin
        case (kind)
            bpu_pkg::KIND_BRANCH: target_pc = fetch_pc_i + b_imm;
            bpu_pkg::KIND_JAL:    target_pc = fetch_pc_i + j_imm;
            default:              target_pc = fall_pc; // jalr target is register based
        endcase
    end

    assign dec_o.kind      = kind;
    assign dec_o.pc        = fetch_pc_i;
    assign dec_o.fall_pc   = fall_pc;
    assign dec_o.target_pc = target_pc;

endmodule

`default_nettype wire

//--- src/bpu_pkg.sv
`default_nettype none

`include "bpu_defs.svh"

package bpu_pkg;

    // control transfer opcodes, rv32i base encoding
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // what the fetched word turned out to be
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JAL    = 2'd2,
        KIND_JALR   = 2'd3
    } inst_kind_e;

    // decoder output toward the selector
    typedef struct packed {
        inst_kind_e            kind;
        logic [`BPU_XLEN-1:0]  pc;        // fetch pc
        logic [`BPU_XLEN-1:0]  fall_pc;   // pc + 4
        logic [`BPU_XLEN-1:0]  target_pc; // pc + imm, fall_pc when no static target
    } decode_t;

    // resolve strobe from execute
    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic [`BPU_XLEN-1:0]  pc;
        logic [`BPU_XLEN-1:0]  target;
    } resolve_t;

    // final prediction back to fetch
    typedef struct packed {
        logic                  branch_or_not;
        logic                  pdt_res;
        logic [`BPU_XLEN-1:0]  pdt_pc;
    } prediction_t;

endpackage

`default_nettype wire

//--- src/bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// datapath width, pc and instruction
`define BPU_XLEN 32

// table depths
`define BPU_BIM_ENTRIES 512
`define BPU_BTB_ENTRIES 256

// bimodal index taken from pc[9:1]
`define BPU_BIM_IDX_HI 9
`define BPU_BIM_IDX_LO 1

// btb index pc[9:2], tag is everything above
`define BPU_BTB_IDX_HI 9
`define BPU_BTB_IDX_LO 2
`define BPU_BTB_TAG_LO 10
`define BPU_BTB_TAG_W 22

// 2-bit saturating counter values
`define BPU_CTR_MIN  2'd0
`define BPU_CTR_INIT 2'd1 // weakly not-taken
`define BPU_CTR_MAX  2'd3

// instruction field positions
`define BPU_OPC_HI 6
`define BPU_OPC_LO 0

`endif
